// File: hw/alu_config.svh
// ALU configuration macros

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath and packed lane widths
`define ALU_XLEN        64
`define ALU_LANE_W      8

// Result buffer entries, also the upstream credit pool
`define ALU_BUF_DEPTH   4

// Credits granted by the downstream at reset
`define ALU_OUT_CREDITS 2

// Lane saturation limit for PL_G
`define ALU_SAT_MAX     127

`endif

// File: hw/alu_pkg.sv
// ALU shared types

`include "alu_config.svh"

package alu_pkg;

    // --------------------
    // Opcodes
    // --------------------
    typedef enum logic [7:0] {
        // Adder and logic
        ADD, SUB, ADDW, SUBW,
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        // Shifts
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // Set less than
        SLTS, SLTU,
        // Branch compares
        EQ, NE, LTS, LTU, GES, GEU,
        // Packed lane ops
        PL_F, PL_G, PL_R
    } alu_op_e;

    // --------------------
    // Data types
    // --------------------
    typedef logic [`ALU_XLEN-1:0]   xlen_t;
    typedef logic [`ALU_LANE_W-1:0] lane_t;

    // Lanes per data word
    localparam int ALU_LANES = `ALU_XLEN / `ALU_LANE_W;

endpackage

// File: hw/alu_issue_stage.sv
// ALU issue stage

`timescale 1ns/1ps

module alu_issue_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             req_valid_i,
    input  alu_pkg::alu_op_e req_op_i,
    input  alu_pkg::xlen_t   req_operand_a_i,
    input  alu_pkg::xlen_t   req_operand_b_i,
    input  alu_pkg::xlen_t   req_imm_i,
    output logic             iss_valid_o,
    output alu_pkg::alu_op_e iss_op_o,
    output alu_pkg::xlen_t   iss_a_o,
    output alu_pkg::xlen_t   iss_b_o,
    output alu_pkg::xlen_t   iss_imm_o,
    output logic             iss_is_lane_o
);

    import alu_pkg::*;

    logic req_is_lane;

    // Unit classification, done once here for the whole datapath
    assign req_is_lane = req_op_i inside {PL_F, PL_G, PL_R};

    // --------------------
    // Issue register
    // --------------------

    // Valid bit is the only control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            iss_valid_o <= 1'b0;
        end else begin
            iss_valid_o <= req_valid_i;
        end
    end

    // Payload loads on accepted requests only
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            iss_op_o      <= req_op_i;
            iss_a_o       <= req_operand_a_i;
            iss_b_o       <= req_operand_b_i;
            iss_imm_o     <= req_imm_i;
            iss_is_lane_o <= req_is_lane;
        end
    end

    // --------------------
    // Assertions
    // --------------------

    // Upstream only issues defined opcodes
    a_legal_op: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> (!$isunknown(req_op_i) && (req_op_i <= PL_R))
    ) else $error("issue stage: illegal opcode on an accepted request");

endmodule

// File: hw/int_exec_unit.sv
// Integer execution unit

`timescale 1ns/1ps

`include "alu_config.svh"

module int_exec_unit (
    input  alu_pkg::alu_op_e iss_op_i,
    input  alu_pkg::xlen_t   iss_a_i,
    input  alu_pkg::xlen_t   iss_b_i,
    output alu_pkg::xlen_t   int_result_o,
    output logic             int_branch_o
);

    import alu_pkg::*;

    localparam int XLEN = `ALU_XLEN;
    localparam int SHW  = $clog2(`ALU_XLEN);

    logic          b_negate;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] operand_b_neg;
    logic [XLEN:0] adder_sum;
    xlen_t         adder_result;
    logic          adder_zero;
    logic          less_signed;
    logic          less;
    xlen_t         a_rev;
    logic [31:0]   a_rev32;
    logic          shift_left;
    logic          shift_arith;
    xlen_t         shift_in;
    logic [31:0]   shift_in32;
    logic [XLEN:0] shr_result;
    logic [32:0]   shr_result32;
    xlen_t         shl_result;
    logic [31:0]   shl_result32;
    xlen_t         shift_result;
    logic [31:0]   shift_result32;

    // --------------------
    // Adder
    // --------------------
    always_comb begin
        case (iss_op_i)
            SUB, SUBW, EQ, NE, ANDN, ORN, XNOR: b_negate = 1'b1;
            default:                            b_negate = 1'b0;
        endcase
    end

    // LSB of 1 on both sides makes the carry in for subtraction
    assign adder_in_a    = {iss_a_i, 1'b1};
    assign operand_b_neg = {iss_b_i, 1'b0} ^ {(XLEN + 1){b_negate}};
    assign adder_sum     = adder_in_a + operand_b_neg;
    assign adder_result  = adder_sum[XLEN:1];
    assign adder_zero    = ~|adder_result;

    // Signed or unsigned compare via one extra sign bit
    assign less_signed = (iss_op_i == SLTS) || (iss_op_i == LTS) || (iss_op_i == GES);
    assign less = $signed({less_signed & iss_a_i[XLEN-1], iss_a_i})
                < $signed({less_signed & iss_b_i[XLEN-1], iss_b_i});

    // --------------------
    // Shifter
    // --------------------
    assign shift_left  = (iss_op_i == SLL) || (iss_op_i == SLLW);
    assign shift_arith = (iss_op_i == SRA) || (iss_op_i == SRAW);

    // Left shifts run through the right shifter on reversed bits
    for (genvar k = 0; k < XLEN; k++) begin : g_rev64
        assign a_rev[k]      = iss_a_i[XLEN-1-k];
        assign shl_result[k] = shr_result[XLEN-1-k];
    end

    for (genvar k = 0; k < 32; k++) begin : g_rev32
        assign a_rev32[k]      = iss_a_i[31-k];
        assign shl_result32[k] = shr_result32[31-k];
    end

    assign shift_in   = shift_left ? a_rev : iss_a_i;
    assign shift_in32 = shift_left ? a_rev32 : iss_a_i[31:0];

    assign shr_result   = $unsigned($signed({shift_arith & shift_in[XLEN-1], shift_in})
                        >>> iss_b_i[SHW-1:0]);
    assign shr_result32 = $unsigned($signed({shift_arith & shift_in32[31], shift_in32})
                        >>> iss_b_i[4:0]);

    assign shift_result   = shift_left ? shl_result : shr_result[XLEN-1:0];
    assign shift_result32 = shift_left ? shl_result32 : shr_result32[31:0];

    // --------------------
    // Result and branch
    // --------------------
    always_comb begin
        case (iss_op_i)
            ADD, SUB:         int_result_o = adder_result;
            ADDW, SUBW:       int_result_o = {{(XLEN-32){adder_result[31]}}, adder_result[31:0]};
            ANDL, ANDN:       int_result_o = iss_a_i & operand_b_neg[XLEN:1];
            ORL, ORN:         int_result_o = iss_a_i | operand_b_neg[XLEN:1];
            XORL, XNOR:       int_result_o = iss_a_i ^ operand_b_neg[XLEN:1];
            SLL, SRL, SRA:    int_result_o = shift_result;
            SLLW, SRLW, SRAW: int_result_o = {{(XLEN-32){shift_result32[31]}}, shift_result32};
            SLTS, SLTU:       int_result_o = {{(XLEN-1){1'b0}}, less};
            // Branches and lane ops carry no integer data
            default:          int_result_o = '0;
        endcase
    end

    always_comb begin
        case (iss_op_i)
            EQ:       int_branch_o = adder_zero;
            NE:       int_branch_o = ~adder_zero;
            LTS, LTU: int_branch_o = less;
            GES, GEU: int_branch_o = ~less;
            default:  int_branch_o = 1'b1;
        endcase
    end

endmodule

// File: hw/lane_exec_unit.sv
// Packed lane execution unit

`timescale 1ns/1ps

`include "alu_config.svh"

module lane_exec_unit (
    input  alu_pkg::alu_op_e iss_op_i,
    input  alu_pkg::xlen_t   iss_a_i,
    input  alu_pkg::xlen_t   iss_b_i,
    input  alu_pkg::xlen_t   iss_imm_i,
    output alu_pkg::xlen_t   lane_result_o
);

    import alu_pkg::*;

    localparam int LW = `ALU_LANE_W;

    // Symmetric clamp bounds in one extra bit
    localparam logic signed [LW:0] SAT_HI = `ALU_SAT_MAX;
    localparam logic signed [LW:0] SAT_LO = -SAT_HI;

    function automatic lane_t saturate(input logic signed [LW:0] value);
        logic signed [LW:0] clamped;
        if (value > SAT_HI) begin
            clamped = SAT_HI;
        end else if (value < SAT_LO) begin
            clamped = SAT_LO;
        end else begin
            clamped = value;
        end
        return clamped[LW-1:0];
    endfunction

    xlen_t func_f;
    xlen_t func_g;
    xlen_t func_r;
    logic  r_clear;

    // PL_R is cleared for every lane when the low byte of b is 1
    assign r_clear = (iss_b_i[LW-1:0] == LW'(1));

    // --------------------
    // Per lane datapath
    // --------------------
    for (genvar i = 0; i < ALU_LANES; i++) begin : g_lane
        lane_t              a_l;
        lane_t              b_l;
        lane_t              abs_a;
        lane_t              abs_b;
        lane_t              min_mag;
        logic               neg;
        logic signed [LW:0] sum;
        logic signed [LW:0] diff;

        assign a_l = iss_a_i[i*LW +: LW];
        assign b_l = iss_b_i[i*LW +: LW];

        // PL_F, magnitude of -128 stays 0x80 as an unsigned value
        assign neg     = a_l[LW-1] ^ b_l[LW-1];
        assign abs_a   = a_l[LW-1] ? lane_t'(-a_l) : a_l;
        assign abs_b   = b_l[LW-1] ? lane_t'(-b_l) : b_l;
        assign min_mag = (abs_a > abs_b) ? abs_b : abs_a;
        assign func_f[i*LW +: LW] = neg ? lane_t'(-min_mag) : min_mag;

        // PL_G, immediate byte picks add or reverse subtract
        assign sum  = {a_l[LW-1], a_l} + {b_l[LW-1], b_l};
        assign diff = {b_l[LW-1], b_l} - {a_l[LW-1], a_l};
        assign func_g[i*LW +: LW] = (iss_imm_i[i*LW +: LW] == '0) ? saturate(sum)
                                                                   : saturate(diff);

        // PL_R
        assign func_r[i*LW +: LW] = r_clear ? '0 : lane_t'(a_l[LW-1]);
    end

    always_comb begin
        case (iss_op_i)
            PL_F:    lane_result_o = func_f;
            PL_G:    lane_result_o = func_g;
            PL_R:    lane_result_o = func_r;
            default: lane_result_o = '0;
        endcase
    end

endmodule

// File: hw/result_buffer.sv
// ALU result buffer

`timescale 1ns/1ps

`include "alu_config.svh"

module result_buffer #(
    parameter int DEPTH = `ALU_BUF_DEPTH
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           iss_valid_i,
    input  logic           iss_is_lane_i,
    input  alu_pkg::xlen_t int_result_i,
    input  alu_pkg::xlen_t lane_result_i,
    input  logic           int_branch_i,
    input  logic           res_credit_i,
    output logic           res_valid_o,
    output alu_pkg::xlen_t res_result_o,
    output logic           res_branch_o,
    output logic           req_credit_o
);

    import alu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CRD_W = $clog2(`ALU_OUT_CREDITS + 1);

    xlen_t            data_q [DEPTH];
    logic             branch_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [CRD_W-1:0] credits;
    logic             empty;
    logic             full;
    logic             send;
    xlen_t            wr_data;

    assign wr_data = iss_is_lane_i ? lane_result_i : int_result_i;
    assign empty   = (count == '0);
    assign full    = (count == (PTR_W + 1)'(DEPTH));

    // Oldest entry goes out whenever the downstream has room
    assign send         = !empty && (credits != '0);
    assign res_valid_o  = send;
    assign res_result_o = data_q[rd_ptr];
    assign res_branch_o = branch_q[rd_ptr];
    // A sent result frees one slot upstream
    assign req_credit_o = send;

    // --------------------
    // Queue storage
    // --------------------
    always_ff @(posedge clk_i) begin
        if (iss_valid_i) begin
            data_q[wr_ptr]   <= wr_data;
            branch_q[wr_ptr] <= int_branch_i;
        end
    end

    // Pointers wrap naturally for a power of two depth
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (iss_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({iss_valid_i, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // Downstream credits
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits <= CRD_W'(`ALU_OUT_CREDITS);
        end else begin
            case ({res_credit_i, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Upstream credit pool must keep the queue from overflowing
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) iss_valid_i |-> !full
    ) else $error("result buffer: write into a full queue");

    // Downstream never returns more credits than it was granted
    a_credit_max: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) credits <= CRD_W'(`ALU_OUT_CREDITS)
    ) else $error("result buffer: downstream credit count above its limit");

endmodule

// File: hw/alu_top.sv
// ALU top level

`timescale 1ns/1ps

module alu_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // Upstream requests
    input  logic             req_valid_i,
    input  alu_pkg::alu_op_e req_op_i,
    input  alu_pkg::xlen_t   req_operand_a_i,
    input  alu_pkg::xlen_t   req_operand_b_i,
    input  alu_pkg::xlen_t   req_imm_i,
    output logic             req_credit_o,
    // Downstream results
    output logic             res_valid_o,
    output alu_pkg::xlen_t   res_result_o,
    output logic             res_branch_o,
    input  logic             res_credit_i
);

    import alu_pkg::*;

    logic    iss_valid;
    alu_op_e iss_op;
    xlen_t   iss_a;
    xlen_t   iss_b;
    xlen_t   iss_imm;
    logic    iss_is_lane;
    xlen_t   int_result;
    logic    int_branch;
    xlen_t   lane_result;

    alu_issue_stage u_issue (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_operand_a_i (req_operand_a_i),
        .req_operand_b_i (req_operand_b_i),
        .req_imm_i       (req_imm_i),
        .iss_valid_o     (iss_valid),
        .iss_op_o        (iss_op),
        .iss_a_o         (iss_a),
        .iss_b_o         (iss_b),
        .iss_imm_o       (iss_imm),
        .iss_is_lane_o   (iss_is_lane)
    );

    // Both units see every issued op
    int_exec_unit u_int (
        .iss_op_i     (iss_op),
        .iss_a_i      (iss_a),
        .iss_b_i      (iss_b),
        .int_result_o (int_result),
        .int_branch_o (int_branch)
    );

    lane_exec_unit u_lane (
        .iss_op_i      (iss_op),
        .iss_a_i       (iss_a),
        .iss_b_i       (iss_b),
        .iss_imm_i     (iss_imm),
        .lane_result_o (lane_result)
    );

    result_buffer u_rbuf (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .iss_valid_i   (iss_valid),
        .iss_is_lane_i (iss_is_lane),
        .int_result_i  (int_result),
        .lane_result_i (lane_result),
        .int_branch_i  (int_branch),
        .res_credit_i  (res_credit_i),
        .res_valid_o   (res_valid_o),
        .res_result_o  (res_result_o),
        .res_branch_o  (res_branch_o),
        .req_credit_o  (req_credit_o)
    );

endmodule

// File: verif/alu_tb.sv
// ALU credit flow testbench

`timescale 1ns/1ps

`include "alu_config.svh"

module alu_tb;

    import alu_pkg::*;

    localparam int MAX_VEC  = 256;
    localparam int HOLD_LEN = 20;

    logic    clk;
    logic    rst_n;
    logic    req_valid;
    alu_op_e req_op;
    xlen_t   req_a;
    xlen_t   req_b;
    xlen_t   req_imm;
    logic    req_credit;
    logic    res_valid;
    xlen_t   res_result;
    logic    res_branch;
    logic    res_credit;

    // Vectors from the stim file
    logic [7:0] vec_op  [MAX_VEC];
    xlen_t      vec_a   [MAX_VEC];
    xlen_t      vec_b   [MAX_VEC];
    xlen_t      vec_imm [MAX_VEC];
    xlen_t      vec_res [MAX_VEC];
    logic       vec_br  [MAX_VEC];
    int         n_vec;
    int         next_vec;

    // Vector indices in request order
    int exp_idx_q [$];
    // Cycles at which downstream credits go back
    int ret_due_q [$];

    int          cycle = 0;
    int          cycle_limit = 0;
    int          up_credits;
    int          got_results;
    int          granted;
    int          err_count;
    int          first_req_cycle;
    logic        hold_credits;
    logic [31:0] rng_state;

    alu_top uut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .req_valid_i     (req_valid),
        .req_op_i        (req_op),
        .req_operand_a_i (req_a),
        .req_operand_b_i (req_b),
        .req_imm_i       (req_imm),
        .req_credit_o    (req_credit),
        .res_valid_o     (res_valid),
        .res_result_o    (res_result),
        .res_branch_o    (res_branch),
        .res_credit_i    (res_credit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            err_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [7:0]  op_v;
        xlen_t       a_v;
        xlen_t       b_v;
        xlen_t       imm_v;
        xlen_t       res_v;
        logic [3:0]  br_v;
        fd = $fopen("verif/alu_stim.txt", "r");
        if (fd == 0) begin
            $display("** Error: cannot open the stimulus file verif/alu_stim.txt");
            $display("Done: errors found");
            $fatal(1, "stimulus file missing");
        end else begin
            n_vec = 0;
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comment and blank lines
                if (line.len() > 2 && line.getc(0) != "/") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h", op_v, a_v, b_v, imm_v, res_v, br_v);
                    if (cnt == 6) begin
                        vec_op[n_vec]  = op_v;
                        vec_a[n_vec]   = a_v;
                        vec_b[n_vec]   = b_v;
                        vec_imm[n_vec] = imm_v;
                        vec_res[n_vec] = res_v;
                        vec_br[n_vec]  = br_v[0];
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_request(input int i);
        req_valid = 1'b1;
        req_op    = alu_op_e'(vec_op[i]);
        req_a     = vec_a[i];
        req_b     = vec_b[i];
        req_imm   = vec_imm[i];
        exp_idx_q.push_back(i);
        up_credits--;
    endtask

    // Sends one request per held credit from a rising edge
    task automatic step_upstream();
        #1;
        if (up_credits > 0 && next_vec < n_vec) begin
            drive_request(next_vec);
            next_vec++;
        end else begin
            req_valid = 1'b0;
        end
        @(posedge clk);
    endtask

    // --------------------
    // Downstream model
    // --------------------
    always @(posedge clk) begin
        #1;
        if (rst_n && !hold_credits && ret_due_q.size() > 0 && ret_due_q[0] <= cycle) begin
            res_credit = 1'b1;
            void'(ret_due_q.pop_front());
        end else begin
            res_credit = 1'b0;
        end
    end

    always @(negedge clk) begin : monitor
        int      idx;
        alu_op_e op_v;
        if (rst_n) begin
            check_value("credit pulse with result", res_valid, req_credit);
            if (req_credit) begin
                up_credits++;
            end
            if (res_valid) begin
                check_value("result with request pending", 1, exp_idx_q.size() > 0);
                idx  = exp_idx_q.pop_front();
                op_v = alu_op_e'(vec_op[idx]);
                check_value($sformatf("vec %0d %s result", idx, op_v.name()),
                            vec_res[idx], res_result);
                check_value($sformatf("vec %0d %s branch", idx, op_v.name()),
                            vec_br[idx], res_branch);
                got_results++;
                check_value("sends within granted credits", 1, got_results <= granted);
                if (got_results == 1) begin
                    check_value("first result latency", first_req_cycle + 2, cycle);
                end
                // Random return delay of 0 to 3 cycles
                ret_due_q.push_back(cycle + 1 + int'(rng_state % 4));
                rng_state = xorshift32(rng_state);
            end
            if (res_credit) begin
                granted++;
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle < cycle_limit) begin
            @(negedge clk);
        end
        $display("** Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $fatal(1, "simulation timed out");
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_op        = ADD;
        req_a         = '0;
        req_b         = '0;
        req_imm       = '0;
        res_credit    = 1'b0;
        hold_credits  = 1'b0;
        up_credits    = `ALU_BUF_DEPTH;
        granted       = `ALU_OUT_CREDITS;
        got_results   = 0;
        err_count     = 0;
        rng_state     = 32'd76001;
        read_vectors();
        cycle_limit = 20 * n_vec + 50;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Lone first request into an empty buffer
        drive_request(0);
        first_req_cycle = cycle;
        next_vec = 1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(posedge clk);
        while (got_results < 1 || ret_due_q.size() > 0) begin
            @(posedge clk);
        end

        // Downstream holds its credits, upstream fills the buffer
        hold_credits = 1'b1;
        repeat (HOLD_LEN) step_upstream();
        check_value("upstream credits under hold", 0, up_credits);
        check_value("results under hold", granted, got_results);
        hold_credits = 1'b0;

        while (next_vec < n_vec) begin
            step_upstream();
        end
        #1;
        req_valid = 1'b0;
        while (got_results < n_vec) begin
            @(posedge clk);
        end

        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_issue_stage.sv
hw/int_exec_unit.sv
hw/lane_exec_unit.sv
hw/result_buffer.sv
hw/alu_top.sv
verif/alu_tb.sv

// File: verif/alu_stim.txt
// op a b imm expected_result expected_branch, all in hex
// op is the alu_op_e code, ADD=00 through PL_R=1a
00 0000000000000005 0000000000000003 0000000000000000 0000000000000008 1
00 7fffffffffffffff 0000000000000001 0000000000000000 8000000000000000 1
01 0000000000000003 0000000000000005 0000000000000000 fffffffffffffffe 1
02 000000007fffffff 0000000000000001 0000000000000000 ffffffff80000000 1
02 123456780000ffff 0000000100000001 0000000000000000 0000000000010000 1
03 0000000000000000 0000000000000001 0000000000000000 ffffffffffffffff 1
03 ffffffff00000005 0000000000000003 0000000000000000 0000000000000002 1
04 f0f0f0f0ff00ff00 ccccaaaa0f0f3333 0000000000000000 c0c0a0a00f003300 1
05 f0f0f0f0ff00ff00 ccccaaaa0f0f3333 0000000000000000 fcfcfafaff0fff33 1
06 f0f0f0f0ff00ff00 ccccaaaa0f0f3333 0000000000000000 3c3c5a5af00fcc33 1
07 f0f0f0f0ff00ff00 ccccaaaa0f0f3333 0000000000000000 30305050f000cc00 1
08 f0f0f0f0ff00ff00 ccccaaaa0f0f3333 0000000000000000 f3f3f5f5fff0ffcc 1
09 f0f0f0f0ff00ff00 ccccaaaa0f0f3333 0000000000000000 c3c3a5a50ff033cc 1
0a 8000000000000001 0000000000000000 0000000000000000 8000000000000001 1
0a 8000000000000001 000000000000003f 0000000000000000 8000000000000000 1
0b 8000000000000001 000000000000001f 0000000000000000 0000000100000000 1
0b 8000000000000001 0000000000000020 0000000000000000 0000000080000000 1
0c 8000000000000001 0000000000000020 0000000000000000 ffffffff80000000 1
0c 8000000000000001 000000000000003f 0000000000000000 ffffffffffffffff 1
0d 1234567880000001 0000000000000020 0000000000000000 ffffffff80000001 1
0d 1234567880000001 000000000000001f 0000000000000000 ffffffff80000000 1
0e 1234567880000001 000000000000003f 0000000000000000 0000000000000001 1
0e 1234567880000001 0000000000000021 0000000000000000 0000000040000000 1
0f 1234567880000001 000000000000001f 0000000000000000 ffffffffffffffff 1
0f 1234567880000001 0000000000000020 0000000000000000 ffffffff80000001 1
10 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000001 1
11 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 1
12 0000000000000005 0000000000000005 0000000000000000 0000000000000000 1
12 0000000000000005 0000000000000006 0000000000000000 0000000000000000 0
13 0000000000000005 0000000000000006 0000000000000000 0000000000000000 1
13 0000000000000005 0000000000000005 0000000000000000 0000000000000000 0
14 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 1
15 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 0
16 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 0
17 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 1
18 8005fb7f10f003fd 7ffe0381f0808002 0000000000000000 81fefd81f010fdfe 1
18 808001007f02ff40 8001ff057f02ffc0 0000000000000000 80ffff007f0201c0 1
19 7f8040c001ff649c 01ff40c0ff01649c 0000000000000000 7f817f8100007f81 1
19 1080057f3010f605 207f03802005f6fa 000100ff00800001 307f088150f5ecf5 1
1a 80ff7f0001fe8000 a5a5a5a5a5a5a501 0000000000000000 0000000000000000 1
1a 80ff7f0001fe8000 0000000000000102 0000000000000000 0101000000010100 1
